//--- src/gpr_pkg.sv
package gpr_pkg;

	// register width of the integer core
	parameter int xlen = 32; // rv32i word
	parameter int gpr_idx_w = 5; // x0..x31 index bits
	parameter int gpr_cnt = 1 << gpr_idx_w; // 32 architectural registers

	// one register value
	typedef logic [xlen-1:0] gpr_data_t; // one word

	// register index as it appears in rs1/rs2/rd fields
	typedef logic [gpr_idx_w-1:0] gpr_idx_t;

	// hardwired zero register
	localparam gpr_idx_t gpr_x0 = gpr_idx_t'(0); // reads as zero, writes dropped

	// link register, read directly by the jalr path
	localparam gpr_idx_t gpr_x1 = gpr_idx_t'(1); // ra

endpackage

//--- src/gpr_rd_if.sv
interface gpr_rd_if import gpr_pkg::*; ();

	logic req; // read request, held until grant
	gpr_idx_t addr; // register index, stable with req
	logic grant; // same cycle as req when this side wins
	gpr_data_t dout; // read data, valid only with grant

	// reader side
	modport requester (
		output req,
		output addr,
		input grant,
		input dout
	);

	// register file / arbiter side
	modport port (
		input req,
		input addr,
		output grant,
		output dout
	);

endinterface

//--- src/gpr_file.sv
module gpr_file import gpr_pkg::*; (
	input logic clk,
	input logic resetn,

	// writeback port
	input logic wr_en, // write strobe
	input gpr_idx_t wr_addr, // destination register
	input gpr_data_t wr_data, // writeback value

	// shared read port #0
	gpr_rd_if.port rd,

	// x1 always visible for the jalr path
	output gpr_data_t x1_v
);

	gpr_data_t regs [1:gpr_cnt-1]; // x0 has no storage

	logic wr_hit; // valid write to a real register

	assign wr_hit = wr_en & (wr_addr != gpr_x0); // writes to x0 are dropped

	// write port, new value readable from the next cycle
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int i = 1; i < gpr_cnt; i++)
			begin
				regs[i] <= '0; // all registers come up zero
			end
		end
		else if (wr_hit)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// async read, port #0 never stalls
	always_comb
	begin
		rd.grant = rd.req; // single consumer after arbiter
		if (rd.addr == gpr_x0)
		begin
			rd.dout = '0; // zero register
		end
		else
		begin
			rd.dout = regs[rd.addr];
		end
	end

	assign x1_v = regs[gpr_x1]; // dedicated link register tap

endmodule

//--- src/gpr_rd_arbiter.sv
module gpr_rd_arbiter #(
	parameter bit jalr_first = 1'b1 // jalr reader wins a tie
) (
	// jalr base address reader
	gpr_rd_if.port jalr,

	// operand reader
	gpr_rd_if.port opnd,

	// toward register file read port #0
	gpr_rd_if.requester file
);

	logic jalr_win; // jalr reader owns the port this cycle
	logic opnd_win; // operand reader owns the port this cycle

	// fixed priority, loser keeps req up and retries
	always_comb
	begin
		if (jalr_first)
		begin
			jalr_win = jalr.req;
			opnd_win = opnd.req & ~jalr.req; // waits while jalr asks
		end
		else
		begin
			opnd_win = opnd.req;
			jalr_win = jalr.req & ~opnd.req; // waits while operand asks
		end
	end

	// forward winner to the file
	assign file.req = jalr_win | opnd_win;
	assign file.addr = jalr_win ? jalr.addr : opnd.addr; // opnd addr when idle, harmless

	// grant only to the winner
	assign jalr.grant = jalr_win & file.grant;
	assign opnd.grant = opnd_win & file.grant;

	// data fans out, qualified by grant at each reader
	assign jalr.dout = file.dout;
	assign opnd.dout = file.dout;

endmodule

//--- src/jalr_baseaddr_rd.sv
module jalr_baseaddr_rd import gpr_pkg::*; (
	input logic clk,
	input logic resetn,

	// hazard state from decode
	input logic rs1_raw_dpc, // rs1 has a pending write

	input gpr_idx_t rs1_id, // base register index

	// x1 tap and shared read port #0
	input gpr_data_t x1_v,
	gpr_rd_if.requester rd,

	// fetch status
	input logic imem_access_resp_valid, // new instruction this cycle
	input logic is_jalr_inst, // current instruction is jalr
	output logic jalr_baseaddr_vld, // base address ready
	output gpr_data_t jalr_baseaddr_v // base address
);

	logic src_x0; // rs1 is zero register
	logic src_x1; // rs1 is link register
	logic need_p0; // rs1 comes through port #0
	logic need_x1; // rs1 comes from x1 tap
	logic p0_pend; // port request still owed
	logic x1_pend; // x1 read waiting on hazard

	logic fetch_hit; // base obtained this cycle
	gpr_data_t fetch_v; // base obtained this cycle
	logic vld_ext; // stretched done flag
	gpr_data_t base_q; // held base

	assign src_x0 = (rs1_id == gpr_x0);
	assign src_x1 = (rs1_id == gpr_x1);
	assign need_p0 = is_jalr_inst & ~src_x0 & ~src_x1; // x2..x31
	assign need_x1 = is_jalr_inst & src_x1;

	// port #0 request, never while rs1 hazard open
	assign rd.req = (imem_access_resp_valid | p0_pend) & need_p0 & ~rs1_raw_dpc;
	assign rd.addr = rs1_id; // held with the instruction

	// keep asking until grant
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			p0_pend <= 1'b0;
		else
			p0_pend <= (p0_pend | (imem_access_resp_valid & need_p0)) & ~rd.grant;
	end

	// x1 waits for raw to clear
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			x1_pend <= 1'b0;
		else
			x1_pend <= (x1_pend | (imem_access_resp_valid & need_x1)) & rs1_raw_dpc;
	end

	// done this cycle, by source
	always_comb
	begin
		fetch_hit = 1'b0;
		if ((imem_access_resp_valid | p0_pend | x1_pend) & is_jalr_inst)
		begin
			if (src_x0)
				fetch_hit = 1'b1; // immediate
			else if (src_x1)
				fetch_hit = ~rs1_raw_dpc; // once hazard gone
			else
				fetch_hit = rd.grant; // on port grant
		end
	end

	// zero for x0, tap for x1, port otherwise
	assign fetch_v = src_x0 ? '0 : (src_x1 ? x1_v : rd.dout);

	// new fetch masks the stretched flag of the old instruction
	assign jalr_baseaddr_vld = fetch_hit | (vld_ext & ~imem_access_resp_valid);
	assign jalr_baseaddr_v = fetch_hit ? fetch_v : base_q; // bypass fresh result

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			vld_ext <= 1'b0;
		else
			vld_ext <= (vld_ext & ~imem_access_resp_valid) | fetch_hit;
	end

	// base holding register
	always_ff @(posedge clk)
	begin
		if (fetch_hit)
			base_q <= fetch_v;
	end

endmodule

//--- src/operand_rd.sv
module operand_rd import gpr_pkg::*; (
	input logic clk,
	input logic resetn,

	// decoded source operand
	input logic opnd_issue, // one-cycle strobe
	input gpr_idx_t opnd_id, // source register

	// shared read port #0
	gpr_rd_if.requester rd,

	// result
	output logic opnd_vld, // pulse in grant cycle
	output gpr_data_t opnd_v // last operand read
);

	logic pend; // request waiting for grant
	gpr_idx_t idx_q; // latched index while waiting
	gpr_data_t opnd_q; // held operand
	logic issue_acc; // issue accepted, not busy

	assign issue_acc = opnd_issue & ~pend; // issue ignored while pending

	// request straight from issue, then from the latch
	assign rd.req = pend | opnd_issue;
	assign rd.addr = pend ? idx_q : opnd_id;

	// wait for grant
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			pend <= 1'b0;
		else if (pend)
			pend <= ~rd.grant;
		else
			pend <= issue_acc & ~rd.grant; // lost arbitration at issue
	end

	// index for the retried request
	always_ff @(posedge clk)
	begin
		if (issue_acc)
			idx_q <= opnd_id;
	end

	// capture granted data
	always_ff @(posedge clk)
	begin
		if (rd.grant)
			opnd_q <= rd.dout;
	end

	assign opnd_vld = rd.grant; // only granted with a live req
	assign opnd_v = rd.grant ? rd.dout : opnd_q; // bypass, then hold

endmodule

//--- src/gpr_rd_top.sv
module gpr_rd_top import gpr_pkg::*; #(
	parameter bit jalr_first = 1'b1 // tie goes to the jalr reader
) (
	input logic clk,
	input logic resetn,

	// writeback
	input logic wr_en,
	input gpr_idx_t wr_addr,
	input gpr_data_t wr_data,

	// fetch and hazard state
	input logic imem_access_resp_valid,
	input logic is_jalr_inst,
	input gpr_idx_t rs1_id,
	input logic rs1_raw_dpc,

	// jalr base address
	output logic jalr_baseaddr_vld,
	output gpr_data_t jalr_baseaddr_v,

	// operand read
	input logic opnd_issue,
	input gpr_idx_t opnd_id,
	output logic opnd_vld,
	output gpr_data_t opnd_v
);

	gpr_rd_if jalr_rd (); // jalr reader to arbiter
	gpr_rd_if opnd_rd (); // operand reader to arbiter
	gpr_rd_if file_rd (); // arbiter to register file

	gpr_data_t x1_v; // link register tap

	gpr_file u_file (
		.clk (clk),
		.resetn (resetn),
		.wr_en (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd (file_rd),
		.x1_v (x1_v)
	);

	gpr_rd_arbiter #(
		.jalr_first (jalr_first)
	) u_arb (
		.jalr (jalr_rd),
		.opnd (opnd_rd),
		.file (file_rd)
	);

	jalr_baseaddr_rd u_jalr (
		.clk (clk),
		.resetn (resetn),
		.rs1_raw_dpc (rs1_raw_dpc),
		.rs1_id (rs1_id),
		.x1_v (x1_v),
		.rd (jalr_rd),
		.imem_access_resp_valid (imem_access_resp_valid),
		.is_jalr_inst (is_jalr_inst),
		.jalr_baseaddr_vld (jalr_baseaddr_vld),
		.jalr_baseaddr_v (jalr_baseaddr_v)
	);

	operand_rd u_opnd (
		.clk (clk),
		.resetn (resetn),
		.opnd_issue (opnd_issue),
		.opnd_id (opnd_id),
		.rd (opnd_rd),
		.opnd_vld (opnd_vld),
		.opnd_v (opnd_v)
	);

endmodule

//--- bench/tb_gpr_rd_checker.sv
module tb_gpr_rd_checker import gpr_pkg::*; #(
	parameter bit jalr_first = 1'b1 // which reader wins a tie
) (
	input logic clk,
	input logic resetn,
	input logic wr_en,
	input gpr_idx_t wr_addr,
	input gpr_data_t wr_data,
	input logic imem_access_resp_valid,
	input logic is_jalr_inst,
	input gpr_idx_t rs1_id,
	input logic rs1_raw_dpc,
	input logic jalr_baseaddr_vld,
	input gpr_data_t jalr_baseaddr_v,
	input logic opnd_issue,
	input gpr_idx_t opnd_id,
	input logic opnd_vld,
	input gpr_data_t opnd_v,
	output int n_tests, // finished tests
	output int n_fail // failed tests
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_wait = 40; // cycles one read may take

	gpr_data_t model [gpr_cnt]; // mirror of the register file
	int cyc; // cycle counter
	logic j_busy; // jalr read in flight
	logic o_busy; // operand read in flight
	gpr_idx_t j_idx;
	gpr_idx_t o_idx;
	int j_t0; // start cycles
	int o_t0;
	int j_done; // finish cycles
	int o_done;
	logic pair; // jalr fetch and issue in one cycle
	logic hold; // jalr result must stay up
	logic win_bad; // window already reported
	gpr_data_t held_v;
	string win_name; // test covering the fetch window
	logic o_hold; // operand result must stay on opnd_v
	logic o_hold_bad; // operand hold already reported
	gpr_data_t o_held_v;
	string o_win_name; // test covering the operand hold

	// expected register value
	function automatic gpr_data_t ref_reg(input gpr_idx_t idx);
		if (idx == gpr_x0)
			return '0; // hardwired zero
		return model[idx];
	endfunction

	task automatic pass_test(input string name);
		n_tests++;
		$display("PASS %s", name);
	endtask

	task automatic value_mismatch(input string name, input gpr_data_t exp, input gpr_data_t act);
		n_tests++;
		n_fail++;
		$display("FAIL %s: expected %h, actual %h", name, exp, act);
	endtask

	task automatic fault(input string msg);
		n_tests++;
		n_fail++;
		$display("ERROR %s", msg);
	endtask

	// inputs settle 1 ns after the edge, so the edge sees stable values
	always @(posedge clk)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < gpr_cnt; i++)
				model[i] = '0; // file clears on reset
			cyc = 0;
			j_busy = 1'b0;
			o_busy = 1'b0;
			pair = 1'b0;
			hold = 1'b0;
			win_bad = 1'b0;
			win_name = "no jalr vld after reset";
			o_hold = 1'b0;
			o_hold_bad = 1'b0;
			o_win_name = "";
			n_tests = 0;
			n_fail = 0;
		end
		else
		begin
			cyc++;
			if (imem_access_resp_valid)
			begin
				if (!win_bad)
					pass_test(win_name); // old window closed clean
				win_bad = 1'b0;
				hold = 1'b0;
				win_name = "no jalr vld after non-JALR fetch";
				if (j_busy)
					fault($sformatf("jalr x%0d got no jalr_baseaddr_vld before the next fetch",
						j_idx));
				j_busy = 1'b0; // new fetch replaces the old one
				if (is_jalr_inst)
				begin
					j_busy = 1'b1;
					j_idx = rs1_id;
					j_t0 = cyc;
				end
				pair = is_jalr_inst & opnd_issue & ~o_busy; // contention start
			end
			if (opnd_issue && !o_busy)
			begin
				o_busy = 1'b1;
				o_idx = opnd_id;
				o_t0 = cyc;
			end
			if (jalr_baseaddr_vld && j_busy)
			begin
				if (j_idx != gpr_x0 && rs1_raw_dpc)
					fault($sformatf("jalr x%0d returned while its RAW hazard was open", j_idx));
				else if (jalr_baseaddr_v !== ref_reg(j_idx))
					value_mismatch($sformatf("jalr x%0d", j_idx), ref_reg(j_idx), jalr_baseaddr_v);
				else
					pass_test($sformatf("jalr x%0d", j_idx));
				j_busy = 1'b0;
				j_done = cyc;
				hold = 1'b1; // held until next fetch
				held_v = ref_reg(j_idx);
				win_name = $sformatf("jalr x%0d held until next fetch", j_idx);
			end
			else if (jalr_baseaddr_vld != hold && !j_busy && !win_bad)
			begin
				if (hold)
					fault("jalr_baseaddr_vld dropped before the next fetch");
				else
					fault("jalr_baseaddr_vld rose with no JALR in flight");
				win_bad = 1'b1;
			end
			else if (hold && jalr_baseaddr_v !== held_v && !win_bad)
			begin
				value_mismatch(win_name, held_v, jalr_baseaddr_v); // held value moved
				win_bad = 1'b1;
			end
			if (opnd_vld)
			begin
				if (o_hold && !o_hold_bad)
					pass_test(o_win_name); // old operand stayed until this read
				o_hold = o_busy;
				o_hold_bad = 1'b0;
				if (!o_busy)
					fault("opnd_vld pulsed with no operand read pending");
				else if (opnd_v !== ref_reg(o_idx))
					value_mismatch($sformatf("opnd x%0d", o_idx), ref_reg(o_idx), opnd_v);
				else
					pass_test($sformatf("opnd x%0d", o_idx));
				o_held_v = ref_reg(o_idx);
				o_win_name = $sformatf("opnd x%0d held until next read", o_idx);
				o_busy = 1'b0;
				o_done = cyc;
			end
			else if (o_hold && !o_hold_bad && opnd_v !== o_held_v)
			begin
				value_mismatch(o_win_name, o_held_v, opnd_v); // operand moved between reads
				o_hold_bad = 1'b1;
			end
			if (j_busy && cyc - j_t0 > max_wait)
			begin
				fault($sformatf("jalr x%0d got no jalr_baseaddr_vld within %0d cycles",
					j_idx, max_wait));
				j_busy = 1'b0;
				j_done = cyc;
			end
			if (o_busy && cyc - o_t0 > max_wait)
			begin
				fault($sformatf("opnd x%0d got no opnd_vld within %0d cycles", o_idx, max_wait));
				o_busy = 1'b0;
				o_done = cyc;
			end
			// loser of a tie may not finish first
			if (pair && !j_busy && !o_busy)
			begin
				if (jalr_first ? (o_done < j_done) : (j_done < o_done))
					fault("contention: the lower-priority reader finished first");
				else
					pass_test("contention order");
				pair = 1'b0;
			end
			if (wr_en && wr_addr != gpr_x0)
				model[wr_addr] = wr_data; // visible from the next cycle
		end
	end

endmodule

//--- bench/tb_gpr_rd.sv
module tb_gpr_rd import gpr_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam bit jalr_first = 1'b1; // jalr reader wins ties
	localparam int clk_period = 8;
	localparam int per_test = 40; // cycle bound of one step
	localparam int n_rand_jalr = 8;
	localparam int n_pairs = 4;
	localparam int n_rand_opnd = 16;
	// fill writes, fetches and reads
	localparam int n_steps = 2 * gpr_cnt + 8 + 2 * n_rand_jalr + n_pairs + n_rand_opnd;

	logic clk;
	logic resetn;
	logic wr_en;
	gpr_idx_t wr_addr;
	gpr_data_t wr_data;
	logic imem_access_resp_valid;
	logic is_jalr_inst;
	gpr_idx_t rs1_id;
	logic rs1_raw_dpc;
	logic jalr_baseaddr_vld;
	gpr_data_t jalr_baseaddr_v;
	logic opnd_issue;
	gpr_idx_t opnd_id;
	logic opnd_vld;
	gpr_data_t opnd_v;
	integer seed;
	int n_done;
	int n_fail;
	gpr_idx_t idx_a;

	gpr_rd_top #(
		.jalr_first (jalr_first)
	) u_dut (
		.clk (clk),
		.resetn (resetn),
		.wr_en (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.imem_access_resp_valid (imem_access_resp_valid),
		.is_jalr_inst (is_jalr_inst),
		.rs1_id (rs1_id),
		.rs1_raw_dpc (rs1_raw_dpc),
		.jalr_baseaddr_vld (jalr_baseaddr_vld),
		.jalr_baseaddr_v (jalr_baseaddr_v),
		.opnd_issue (opnd_issue),
		.opnd_id (opnd_id),
		.opnd_vld (opnd_vld),
		.opnd_v (opnd_v)
	);

	tb_gpr_rd_checker #(
		.jalr_first (jalr_first)
	) u_chk (
		.clk (clk),
		.resetn (resetn),
		.wr_en (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.imem_access_resp_valid (imem_access_resp_valid),
		.is_jalr_inst (is_jalr_inst),
		.rs1_id (rs1_id),
		.rs1_raw_dpc (rs1_raw_dpc),
		.jalr_baseaddr_vld (jalr_baseaddr_vld),
		.jalr_baseaddr_v (jalr_baseaddr_v),
		.opnd_issue (opnd_issue),
		.opnd_id (opnd_id),
		.opnd_vld (opnd_vld),
		.opnd_v (opnd_v),
		.n_tests (n_done),
		.n_fail (n_fail)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	// next edge, then the drive offset
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic write_reg(input gpr_idx_t idx, input gpr_data_t val);
		wr_en = 1'b1;
		wr_addr = idx;
		wr_data = val;
		step();
		wr_en = 1'b0;
	endtask

	// jalr fetch, rs1 hazard held for raw_cyc cycles
	task automatic jalr_read(input gpr_idx_t idx, input int raw_cyc);
		int n;
		logic done;
		n = 0;
		imem_access_resp_valid = 1'b1;
		is_jalr_inst = 1'b1;
		rs1_id = idx;
		rs1_raw_dpc = (raw_cyc > 0);
		do
		begin
			@(posedge clk);
			done = jalr_baseaddr_vld; // new result only, old one masked
			#1;
			imem_access_resp_valid = 1'b0;
			n++;
			if (n >= raw_cyc)
				rs1_raw_dpc = 1'b0;
		end
		while (!done && n < per_test);
		repeat ($unsigned($random(seed)) % 4)
			step(); // idle while result is held
	endtask

	task automatic opnd_read(input gpr_idx_t idx);
		int n;
		logic done;
		n = 0;
		opnd_issue = 1'b1;
		opnd_id = idx;
		do
		begin
			@(posedge clk);
			done = opnd_vld;
			#1;
			opnd_issue = 1'b0; // one-cycle strobe
			n++;
		end
		while (!done && n < per_test);
	endtask

	task automatic plain_fetch();
		imem_access_resp_valid = 1'b1;
		is_jalr_inst = 1'b0; // not a jalr
		step();
		imem_access_resp_valid = 1'b0;
		step();
	endtask

	initial
	begin
		seed = 32'hbf6f_2227;
		resetn = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		imem_access_resp_valid = 1'b0;
		is_jalr_inst = 1'b0;
		rs1_id = '0;
		rs1_raw_dpc = 1'b0;
		opnd_issue = 1'b0;
		opnd_id = '0;
		repeat (5)
			@(posedge clk);
		#1;
		resetn = 1'b1;
		for (int i = 1; i < gpr_cnt; i++)
			write_reg(gpr_idx_t'(i), gpr_data_t'($random(seed))); // random fill
		jalr_read(gpr_x0, 0);
		plain_fetch();
		jalr_read(gpr_x1, 0);
		jalr_read(gpr_x1, 1 + $unsigned($random(seed)) % 8); // hazard delays x1
		plain_fetch();
		write_reg(gpr_idx_t'(7), gpr_data_t'($random(seed)));
		jalr_read(gpr_idx_t'(7), 0); // fresh write read back
		for (int i = 0; i < n_rand_jalr; i++)
		begin
			jalr_read(gpr_idx_t'(2 + $unsigned($random(seed)) % 30), 0);
			plain_fetch();
		end
		for (int i = 0; i < n_pairs; i++)
		begin
			idx_a = gpr_idx_t'(2 + $unsigned($random(seed)) % 30);
			fork
				jalr_read(idx_a, 0);
				opnd_read((idx_a == 31) ? gpr_idx_t'(2) : idx_a + 1'b1); // other register
			join
		end
		for (int i = 0; i < gpr_cnt; i++)
			opnd_read(gpr_idx_t'(i));
		for (int i = 0; i < n_rand_opnd; i++)
			opnd_read(gpr_idx_t'($unsigned($random(seed)) % gpr_cnt));
		plain_fetch(); // closes last hold window
		repeat (2)
			step();
		$display("%0d tests, %0d failed", n_done, n_fail);
		if (n_fail == 0 && n_done > 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(n_steps * per_test * clk_period);
		$display("watchdog: run did not finish within %0d cycles", n_steps * per_test);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- all.f
src/gpr_pkg.sv
src/gpr_rd_if.sv
src/gpr_file.sv
src/gpr_rd_arbiter.sv
src/jalr_baseaddr_rd.sv
src/operand_rd.sv
src/gpr_rd_top.sv
bench/tb_gpr_rd_checker.sv
bench/tb_gpr_rd.sv

//--- Bender.yml
package:
  name: gpr_rd

sources:
  - src/gpr_pkg.sv
  - src/gpr_rd_if.sv
  - src/gpr_file.sv
  - src/gpr_rd_arbiter.sv
  - src/jalr_baseaddr_rd.sv
  - src/operand_rd.sv
  - src/gpr_rd_top.sv
  - target: test
    files:
      - bench/tb_gpr_rd_checker.sv
      - bench/tb_gpr_rd.sv
